//--- vlog.f
+incdir+tb
src/acw_pkg.sv
src/acw_csr_bank.sv
src/acw_region_match.sv
src/acw_perm_resolve.sv
src/acw_block_fsm.sv
src/acw_top.sv
tb/acw_tb.sv

//--- run.sh
#!/bin/sh
# Build the firewall testbench with Verilator and run it.
# The exit status is nonzero when the build fails or the testbench stops with $fatal.

cd "$(dirname "$0")" &&
	verilator --binary --timing -f vlog.f --top-module acw_tb -o acw_sim &&
	./obj_dir/acw_sim ||
	exit 1

//--- tb/acw_tb_table.svh
// Stimulus and expected-value table for the firewall testbench, included inside the testbench module
`ifndef ACW_TB_TABLE_SVH
`define ACW_TB_TABLE_SVH

typedef enum logic [2:0] {
	k_cpu_write,
	k_cpu_read,
	k_host,
	k_go_idle,
	k_irq
} step_kind_e;

// columns: step kind, address, data, host write flag, expected outcome
typedef struct packed {
	step_kind_e     kind;
	acw_pkg::addr_t addr;
	acw_pkg::data_t data;
	logic           write;
	logic [1:0]     exp;
} step_t;

// expected outcome, error bit for CPU rows, denial for host rows, level for irq rows
localparam logic [1:0] EXP_0     = 2'd0;
localparam logic [1:0] EXP_1     = 2'd1;
localparam logic [1:0] EXP_BLOCK = 2'd2;

// CPU register addresses, configuration words follow the control registers
localparam acw_pkg::addr_t CPU_BASE      = {BASE_ADDR, 10'b0};
localparam acw_pkg::addr_t A_GO_IDLE     = CPU_BASE + {22'b0, acw_pkg::reg_go_idle, 2'b00};
localparam acw_pkg::addr_t A_DENIED_ADDR = CPU_BASE + {22'b0, acw_pkg::reg_denied_addr, 2'b00};
localparam acw_pkg::addr_t A_DENIED_TYPE = CPU_BASE + {22'b0, acw_pkg::reg_denied_type, 2'b00};
localparam acw_pkg::addr_t A_STATE       = CPU_BASE + {22'b0, acw_pkg::reg_state, 2'b00};
localparam acw_pkg::addr_t A_INTR_STATE  = CPU_BASE + {22'b0, acw_pkg::reg_intr_state, 2'b00};
localparam acw_pkg::addr_t A_INTR_EN     = CPU_BASE + {22'b0, acw_pkg::reg_intr_enable, 2'b00};
localparam acw_pkg::addr_t A_CFG0        = CPU_BASE + 32'(4 * acw_pkg::NUM_CTRL_REGS);
localparam acw_pkg::addr_t A_ADDR0       = A_CFG0 + 32'(NUM_REGIONS);
localparam acw_pkg::addr_t A_UNMAPPED    = A_ADDR0 + 32'(4 * NUM_REGIONS);

localparam int NUM_STEPS = 40;

// region 0 TOR read only below 0x1000, region 1 NAPOT write only below 0x2000,
// region 2 NAPOT read and write at 0x8000 size 0x1000
localparam step_t STEPS [NUM_STEPS] = '{
	'{k_cpu_write, A_CFG0,              32'h001b_1a09, 1'b0, EXP_0},
	'{k_cpu_write, A_ADDR0,             32'h0000_0400, 1'b0, EXP_0},
	'{k_cpu_write, A_ADDR0 + 32'd4,     32'h0000_03ff, 1'b0, EXP_0},
	'{k_cpu_write, A_ADDR0 + 32'd8,     32'h0000_21ff, 1'b0, EXP_0},
	'{k_cpu_read,  A_CFG0,              32'h001b_1a09, 1'b0, EXP_0},
	'{k_cpu_read,  A_ADDR0,             32'h0000_0400, 1'b0, EXP_0},
	'{k_cpu_read,  A_ADDR0 + 32'd8,     32'h0000_21ff, 1'b0, EXP_0},
	'{k_cpu_read,  A_UNMAPPED,          32'h0,         1'b0, EXP_1},
	'{k_cpu_read,  A_INTR_EN + 32'h400, 32'h0,         1'b0, EXP_1},
	'{k_cpu_read,  A_ADDR0 + 32'd1,     32'h0,         1'b0, EXP_1},
	'{k_cpu_write, A_STATE,             32'h3,         1'b0, EXP_1},
	'{k_cpu_read,  A_GO_IDLE,           32'h0,         1'b0, EXP_1},
	'{k_host,      32'h0000_8010,       32'h0,         1'b0, EXP_0},
	'{k_host,      32'h0000_8020,       32'h0,         1'b1, EXP_0},
	'{k_host,      32'h0000_0100,       32'h0,         1'b0, EXP_0},
	'{k_host,      32'h0000_1800,       32'h0,         1'b1, EXP_0},
	// overlap of regions 0 and 1, region 0 has no write permission
	'{k_host,      32'h0000_0200,       32'h0,         1'b1, EXP_1},
	'{k_irq,       32'h0,               32'h0,         1'b0, EXP_0},
	'{k_cpu_read,  A_DENIED_ADDR,       32'h0000_0200, 1'b0, EXP_0},
	'{k_cpu_read,  A_DENIED_TYPE,       32'h0000_0001, 1'b0, EXP_0},
	'{k_cpu_read,  A_STATE,             32'(acw_pkg::st_block_err), 1'b0, EXP_0},
	'{k_cpu_read,  A_INTR_STATE,        32'h8000_0000, 1'b0, EXP_0},
	'{k_host,      32'h0000_8010,       32'h0,         1'b0, EXP_BLOCK},
	'{k_go_idle,   A_GO_IDLE,           32'h0000_0001, 1'b0, EXP_0},
	'{k_cpu_read,  A_STATE,             32'(acw_pkg::st_idle), 1'b0, EXP_0},
	'{k_host,      32'h0000_8010,       32'h0,         1'b0, EXP_0},
	'{k_cpu_write, A_INTR_STATE,        32'h0,         1'b0, EXP_0},
	'{k_cpu_read,  A_INTR_STATE,        32'h0,         1'b0, EXP_0},
	'{k_cpu_write, A_INTR_EN,           32'h8000_0000, 1'b0, EXP_0},
	'{k_cpu_read,  A_INTR_EN,           32'h8000_0000, 1'b0, EXP_0},
	'{k_irq,       32'h0,               32'h0,         1'b0, EXP_0},
	// no region covers this address
	'{k_host,      32'h0000_5000,       32'h0,         1'b0, EXP_1},
	'{k_irq,       32'h0,               32'h0,         1'b0, EXP_1},
	'{k_cpu_read,  A_DENIED_ADDR,       32'h0000_5000, 1'b0, EXP_0},
	'{k_cpu_read,  A_DENIED_TYPE,       32'h0,         1'b0, EXP_0},
	'{k_cpu_write, A_INTR_STATE,        32'h0,         1'b0, EXP_0},
	'{k_irq,       32'h0,               32'h0,         1'b0, EXP_0},
	'{k_cpu_read,  A_INTR_STATE,        32'h0,         1'b0, EXP_0},
	'{k_go_idle,   A_GO_IDLE,           32'h0000_0001, 1'b0, EXP_0},
	'{k_cpu_read,  A_STATE,             32'(acw_pkg::st_idle), 1'b0, EXP_0}
};

`endif

//--- tb/acw_tb.sv
// Testbench for the bus firewall, applies the stimulus table to acw_top and checks each response
`timescale 1ns/1ps

module acw_tb;

	localparam int             NUM_REGIONS = 8;
	localparam logic [21:0]    BASE_ADDR   = 22'h00100;
	localparam int             WAIT_LIMIT  = 20;
	localparam acw_pkg::data_t DEV_XOR     = 32'h5a5a_0f0f;

	`include "acw_tb_table.svh"

	logic clk;
	logic rst;
	logic host_valid_i;
	acw_pkg::addr_t host_addr_i;
	logic host_write_i;
	acw_pkg::data_t host_wdata_i;
	logic host_ready_o;
	logic host_rsp_valid_o;
	acw_pkg::data_t host_rsp_rdata_o;
	logic host_rsp_err_o;
	logic host_rsp_ready_i;
	logic dev_valid_o;
	acw_pkg::addr_t dev_addr_o;
	logic dev_write_o;
	acw_pkg::data_t dev_wdata_o;
	logic dev_ready_i;
	logic dev_rsp_valid_i;
	acw_pkg::data_t dev_rsp_rdata_i;
	logic dev_rsp_err_i;
	logic dev_rsp_ready_o;
	logic cpu_req_i;
	logic cpu_write_i;
	acw_pkg::addr_t cpu_addr_i;
	acw_pkg::data_t cpu_wdata_i;
	logic cpu_rsp_valid_o;
	acw_pkg::data_t cpu_rsp_rdata_o;
	logic cpu_rsp_err_o;
	logic irq_o;

	int dev_req_count;
	acw_pkg::data_t dev_last_wdata;
	integer seed;

	acw_top #(
		.NUM_REGIONS(NUM_REGIONS),
		.BASE_ADDR  (BASE_ADDR)
	) acw_top_inst (
		.clk             (clk),
		.rst             (rst),
		.host_valid_i    (host_valid_i),
		.host_addr_i     (host_addr_i),
		.host_write_i    (host_write_i),
		.host_wdata_i    (host_wdata_i),
		.host_ready_o    (host_ready_o),
		.host_rsp_valid_o(host_rsp_valid_o),
		.host_rsp_rdata_o(host_rsp_rdata_o),
		.host_rsp_err_o  (host_rsp_err_o),
		.host_rsp_ready_i(host_rsp_ready_i),
		.dev_valid_o     (dev_valid_o),
		.dev_addr_o      (dev_addr_o),
		.dev_write_o     (dev_write_o),
		.dev_wdata_o     (dev_wdata_o),
		.dev_ready_i     (dev_ready_i),
		.dev_rsp_valid_i (dev_rsp_valid_i),
		.dev_rsp_rdata_i (dev_rsp_rdata_i),
		.dev_rsp_err_i   (dev_rsp_err_i),
		.dev_rsp_ready_o (dev_rsp_ready_o),
		.cpu_req_i       (cpu_req_i),
		.cpu_write_i     (cpu_write_i),
		.cpu_addr_i      (cpu_addr_i),
		.cpu_wdata_i     (cpu_wdata_i),
		.cpu_rsp_valid_o (cpu_rsp_valid_o),
		.cpu_rsp_rdata_o (cpu_rsp_rdata_o),
		.cpu_rsp_err_o   (cpu_rsp_err_o),
		.irq_o           (irq_o)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#20 clk = ~clk;
		end
	end

	// device model, answers every accepted request one cycle later
	always @(posedge clk or negedge rst) begin
		if (!rst) begin
			dev_rsp_valid_i <= 1'b0;
			dev_rsp_rdata_i <= '0;
			dev_rsp_err_i <= 1'b0;
			dev_req_count <= 0;
			dev_last_wdata <= '0;
		end else begin
			if (dev_rsp_valid_i && dev_rsp_ready_o) begin
				dev_rsp_valid_i <= 1'b0;
			end
			if (dev_valid_o && dev_ready_i) begin
				dev_req_count <= dev_req_count + 1;
				dev_rsp_valid_i <= 1'b1;
				dev_rsp_rdata_i <= dev_write_o ? '0 : (dev_addr_o ^ DEV_XOR);
				dev_rsp_err_i <= 1'b0;
				if (dev_write_o) begin
					dev_last_wdata <= dev_wdata_o;
				end
			end
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Testbench failed");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input acw_pkg::data_t got,
		input acw_pkg::data_t exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input acw_pkg::addr_t got,
		input acw_pkg::addr_t exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_state(input string name, input acw_pkg::block_state_e got,
		input acw_pkg::block_state_e exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_bit(input string name, input logic got, input logic exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED %s got %h expected %h", name, got, exp));
		end
	endtask

	// one strobe cycle, the response comes back one cycle later
	task automatic cpu_access(input logic write, input acw_pkg::addr_t addr,
		input acw_pkg::data_t wdata, output acw_pkg::data_t rdata, output logic err);
		int waited;
		@(posedge clk);
		cpu_req_i <= 1'b1;
		cpu_write_i <= write;
		cpu_addr_i <= addr;
		cpu_wdata_i <= wdata;
		@(posedge clk);
		cpu_req_i <= 1'b0;
		waited = 0;
		@(negedge clk);
		while (cpu_rsp_valid_o !== 1'b1) begin
			waited++;
			if (waited >= WAIT_LIMIT) begin
				stop_run("timeout waiting for the CPU response");
			end
			@(negedge clk);
		end
		rdata = cpu_rsp_rdata_o;
		err = cpu_rsp_err_o;
	endtask

	// taken stays low when host_ready_o never rose within the window
	task automatic host_access(input acw_pkg::addr_t addr, input logic write,
		input acw_pkg::data_t wdata, output logic taken, output acw_pkg::data_t rdata,
		output logic err, output logic rsp_ready);
		int waited;
		rdata = '0;
		err = 1'b0;
		rsp_ready = 1'b0;
		@(posedge clk);
		host_valid_i <= 1'b1;
		host_addr_i <= addr;
		host_write_i <= write;
		host_wdata_i <= wdata;
		waited = 0;
		@(negedge clk);
		while (host_ready_o !== 1'b1 && waited < WAIT_LIMIT) begin
			waited++;
			@(negedge clk);
		end
		taken = (host_ready_o === 1'b1);
		@(posedge clk);
		host_valid_i <= 1'b0;
		if (taken) begin
			waited = 0;
			@(negedge clk);
			while (host_rsp_valid_o !== 1'b1) begin
				waited++;
				if (waited >= WAIT_LIMIT) begin
					stop_run("timeout waiting for the host response");
				end
				@(negedge clk);
			end
			rdata = host_rsp_rdata_o;
			err = host_rsp_err_o;
			rsp_ready = dev_rsp_ready_o;
			@(posedge clk);
		end
	endtask

	initial begin : run_steps
		step_t row;
		acw_pkg::data_t rdata;
		acw_pkg::data_t wdata;
		logic err;
		logic taken;
		logic rsp_ready;
		int count_before;
		seed = 5;
		rst <= 1'b0;
		host_valid_i <= 1'b0;
		host_addr_i <= '0;
		host_write_i <= 1'b0;
		host_wdata_i <= '0;
		host_rsp_ready_i <= 1'b1;
		dev_ready_i <= 1'b1;
		cpu_req_i <= 1'b0;
		cpu_write_i <= 1'b0;
		cpu_addr_i <= '0;
		cpu_wdata_i <= '0;
		repeat (5) @(posedge clk);
		rst <= 1'b1;
		@(negedge clk);
		check_bit("host_rsp_valid_o", host_rsp_valid_o, 1'b0);
		check_bit("cpu_rsp_valid_o", cpu_rsp_valid_o, 1'b0);
		check_bit("irq_o", irq_o, 1'b0);
		for (int i = 0; i < NUM_STEPS; i++) begin
			row = STEPS[i];
			case (row.kind)
				k_cpu_write, k_go_idle: begin
					cpu_access(1'b1, row.addr, row.data, rdata, err);
					check_bit("cpu_rsp_err_o", err, row.exp[0]);
				end
				k_cpu_read: begin
					cpu_access(1'b0, row.addr, '0, rdata, err);
					check_bit("cpu_rsp_err_o", err, row.exp[0]);
					if (row.exp == EXP_0) begin
						if (row.addr == A_DENIED_ADDR) begin
							check_addr("cpu_rsp_rdata_o", rdata, row.data);
						end else if (row.addr == A_STATE) begin
							check_state("cpu_rsp_rdata_o", acw_pkg::block_state_e'(rdata[1:0]),
								acw_pkg::block_state_e'(row.data[1:0]));
						end else begin
							check_data("cpu_rsp_rdata_o", rdata, row.data);
						end
					end
				end
				k_host: begin
					count_before = dev_req_count;
					wdata = '0;
					if (row.write) begin
						wdata = $random(seed);
					end
					host_access(row.addr, row.write, wdata, taken, rdata, err, rsp_ready);
					if (row.exp == EXP_BLOCK) begin
						if (taken) begin
							stop_run("host request was accepted while the firewall was blocked");
						end
						check_data("dev_req_count", 32'(dev_req_count), 32'(count_before));
					end else begin
						if (!taken) begin
							stop_run("timeout waiting for host_ready_o");
						end
						check_bit("host_rsp_err_o", err, row.exp[0]);
						if (row.exp == EXP_1) begin
							check_data("host_rsp_rdata_o", rdata, '0);
							check_data("dev_req_count", 32'(dev_req_count), 32'(count_before));
						end else begin
							check_data("dev_req_count", 32'(dev_req_count), 32'(count_before + 1));
							// the host is always ready, so the device response is taken too
							check_bit("dev_rsp_ready_o", rsp_ready, 1'b1);
							if (row.write) begin
								check_data("dev_wdata_o", dev_last_wdata, wdata);
							end else begin
								check_data("host_rsp_rdata_o", rdata, row.addr ^ DEV_XOR);
							end
						end
					end
				end
				k_irq: begin
					@(negedge clk);
					check_bit("irq_o", irq_o, row.exp[0]);
				end
				default: begin
					stop_run("unknown step kind in the stimulus table");
				end
			endcase
		end
		$display("Testbench passed");
		$finish;
	end

endmodule

//--- src/acw_top.sv
// Bus firewall top level, connects the register bank, region matchers, resolver and blocking FSM
`timescale 1ns/1ps

module acw_top #(
	parameter int          NUM_REGIONS = 8,
	parameter logic [21:0] BASE_ADDR   = 22'h0
) (
	input  logic           clk,
	input  logic           rst,
	input  logic           host_valid_i,
	input  acw_pkg::addr_t host_addr_i,
	input  logic           host_write_i,
	input  acw_pkg::data_t host_wdata_i,
	output logic           host_ready_o,
	output logic           host_rsp_valid_o,
	output acw_pkg::data_t host_rsp_rdata_o,
	output logic           host_rsp_err_o,
	input  logic           host_rsp_ready_i,
	output logic           dev_valid_o,
	output acw_pkg::addr_t dev_addr_o,
	output logic           dev_write_o,
	output acw_pkg::data_t dev_wdata_o,
	input  logic           dev_ready_i,
	input  logic           dev_rsp_valid_i,
	input  acw_pkg::data_t dev_rsp_rdata_i,
	input  logic           dev_rsp_err_i,
	output logic           dev_rsp_ready_o,
	input  logic           cpu_req_i,
	input  logic           cpu_write_i,
	input  acw_pkg::addr_t cpu_addr_i,
	input  acw_pkg::data_t cpu_wdata_i,
	output logic           cpu_rsp_valid_o,
	output acw_pkg::data_t cpu_rsp_rdata_o,
	output logic           cpu_rsp_err_o,
	output logic           irq_o
);

	logic [NUM_REGIONS-1:0][7:0] region_cfg;
	acw_pkg::region_addr_t [NUM_REGIONS-1:0] region_addr;
	acw_pkg::region_addr_t [NUM_REGIONS-1:0] prev_addr;
	logic [NUM_REGIONS-1:0] hit;
	logic [NUM_REGIONS-1:0] allow;
	logic permit;
	logic deny;
	acw_pkg::addr_t denied_addr;
	logic denied_write;
	acw_pkg::block_state_e state;
	logic go_idle;

	acw_csr_bank #(
		.NUM_REGIONS(NUM_REGIONS),
		.BASE_ADDR  (BASE_ADDR)
	) csr_bank_inst (
		.clk            (clk),
		.rst            (rst),
		.cpu_req_i      (cpu_req_i),
		.cpu_write_i    (cpu_write_i),
		.cpu_addr_i     (cpu_addr_i),
		.cpu_wdata_i    (cpu_wdata_i),
		.cpu_rsp_valid_o(cpu_rsp_valid_o),
		.cpu_rsp_rdata_o(cpu_rsp_rdata_o),
		.cpu_rsp_err_o  (cpu_rsp_err_o),
		.region_cfg_o   (region_cfg),
		.region_addr_o  (region_addr),
		.deny_i         (deny),
		.denied_addr_i  (denied_addr),
		.denied_write_i (denied_write),
		.state_i        (state),
		.go_idle_o      (go_idle),
		.irq_o          (irq_o)
	);

	// each region's TOR lower bound is the previous address register, zero for region 0
	assign prev_addr = {region_addr[NUM_REGIONS-2:0], acw_pkg::region_addr_t'(0)};

	for (genvar i = 0; i < NUM_REGIONS; i++) begin : gen_region
		acw_region_match region_match_inst (
			.cfg_i          (region_cfg[i]),
			.addr_reg_i     (region_addr[i]),
			.prev_addr_reg_i(prev_addr[i]),
			.req_addr_i     (host_addr_i),
			.req_write_i    (host_write_i),
			.hit_o          (hit[i]),
			.allow_o        (allow[i])
		);
	end

	acw_perm_resolve #(
		.NUM_REGIONS(NUM_REGIONS)
	) perm_resolve_inst (
		.hit_i   (hit),
		.allow_i (allow),
		.permit_o(permit)
	);

	acw_block_fsm block_fsm_inst (
		.clk             (clk),
		.rst             (rst),
		.host_valid_i    (host_valid_i),
		.host_addr_i     (host_addr_i),
		.host_write_i    (host_write_i),
		.host_wdata_i    (host_wdata_i),
		.host_ready_o    (host_ready_o),
		.host_rsp_valid_o(host_rsp_valid_o),
		.host_rsp_rdata_o(host_rsp_rdata_o),
		.host_rsp_err_o  (host_rsp_err_o),
		.host_rsp_ready_i(host_rsp_ready_i),
		.dev_valid_o     (dev_valid_o),
		.dev_addr_o      (dev_addr_o),
		.dev_write_o     (dev_write_o),
		.dev_wdata_o     (dev_wdata_o),
		.dev_ready_i     (dev_ready_i),
		.dev_rsp_valid_i (dev_rsp_valid_i),
		.dev_rsp_rdata_i (dev_rsp_rdata_i),
		.dev_rsp_err_i   (dev_rsp_err_i),
		.dev_rsp_ready_o (dev_rsp_ready_o),
		.permit_i        (permit),
		.go_idle_i       (go_idle),
		.deny_o          (deny),
		.denied_addr_o   (denied_addr),
		.denied_write_o  (denied_write),
		.state_o         (state)
	);

endmodule

//--- src/acw_block_fsm.sv
// Host to device pass-through with denial, error response and the blocking state machine
`timescale 1ns/1ps

module acw_block_fsm (
	input  logic                  clk,
	input  logic                  rst,
	input  logic                  host_valid_i,
	input  acw_pkg::addr_t        host_addr_i,
	input  logic                  host_write_i,
	input  acw_pkg::data_t        host_wdata_i,
	output logic                  host_ready_o,
	output logic                  host_rsp_valid_o,
	output acw_pkg::data_t        host_rsp_rdata_o,
	output logic                  host_rsp_err_o,
	input  logic                  host_rsp_ready_i,
	output logic                  dev_valid_o,
	output acw_pkg::addr_t        dev_addr_o,
	output logic                  dev_write_o,
	output acw_pkg::data_t        dev_wdata_o,
	input  logic                  dev_ready_i,
	input  logic                  dev_rsp_valid_i,
	input  acw_pkg::data_t        dev_rsp_rdata_i,
	input  logic                  dev_rsp_err_i,
	output logic                  dev_rsp_ready_o,
	input  logic                  permit_i,
	input  logic                  go_idle_i,
	output logic                  deny_o,
	output acw_pkg::addr_t        denied_addr_o,
	output logic                  denied_write_o,
	output acw_pkg::block_state_e state_o
);

	acw_pkg::block_state_e state_q;
	acw_pkg::block_state_e state_d;
	logic err_rsp;

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			state_q <= acw_pkg::st_idle;
		end else begin
			state_q <= state_d;
		end
	end

	// the error response is held in both of these states
	assign err_rsp = (state_q == acw_pkg::st_block_start) || (state_q == acw_pkg::st_block_idle);

	always_comb begin
		state_d = state_q;
		host_ready_o = 1'b0;
		dev_valid_o = 1'b0;
		deny_o = 1'b0;
		host_rsp_valid_o = dev_rsp_valid_i;
		host_rsp_rdata_o = dev_rsp_rdata_i;
		host_rsp_err_o = dev_rsp_err_i;
		dev_rsp_ready_o = host_rsp_ready_i;
		case (state_q)
			acw_pkg::st_idle: begin
				host_ready_o = dev_ready_i;
				dev_valid_o = host_valid_i && permit_i;
				// a denied request is swallowed once the device could have taken it
				if (host_valid_i && dev_ready_i && !permit_i) begin
					deny_o = 1'b1;
					state_d = acw_pkg::st_block_start;
				end
			end
			acw_pkg::st_block_start: begin
				if (host_rsp_ready_i && go_idle_i) begin
					state_d = acw_pkg::st_idle;
				end else if (go_idle_i) begin
					state_d = acw_pkg::st_block_idle;
				end else if (host_rsp_ready_i) begin
					state_d = acw_pkg::st_block_err;
				end
			end
			acw_pkg::st_block_idle: begin
				if (host_rsp_ready_i) begin
					state_d = acw_pkg::st_idle;
				end
			end
			default: begin
				// st_block_err, device responses still flow back to the host
				if (go_idle_i) begin
					state_d = acw_pkg::st_idle;
				end
			end
		endcase
		if (err_rsp) begin
			host_rsp_valid_o = 1'b1;
			host_rsp_rdata_o = '0;
			host_rsp_err_o = 1'b1;
			dev_rsp_ready_o = 1'b0;
		end
	end

	// request payload goes out unchanged, dev_valid_o alone gates it
	assign dev_addr_o = host_addr_i;
	assign dev_write_o = host_write_i;
	assign dev_wdata_o = host_wdata_i;

	// only sampled by the register bank while deny_o is high
	assign denied_addr_o = host_addr_i;
	assign denied_write_o = host_write_i;
	assign state_o = state_q;

endmodule

//--- src/acw_perm_resolve.sv
// Picks the lowest numbered matching region and turns its permission into one permit bit
`timescale 1ns/1ps

module acw_perm_resolve #(
	parameter int NUM_REGIONS = 8
) (
	input  logic [NUM_REGIONS-1:0] hit_i,
	input  logic [NUM_REGIONS-1:0] allow_i,
	output logic                   permit_o
);

	logic found;

	// no hit at all leaves the request denied
	always_comb begin
		found = 1'b0;
		permit_o = 1'b0;
		for (int i = 0; i < NUM_REGIONS; i++) begin
			if (hit_i[i] && !found) begin
				found = 1'b1;
				permit_o = allow_i[i];
			end
		end
	end

endmodule

//--- src/acw_region_match.sv
// Address match and permission check for one protection region, one instance per region
`timescale 1ns/1ps

module acw_region_match (
	input  logic [7:0]            cfg_i,
	input  acw_pkg::region_addr_t addr_reg_i,
	input  acw_pkg::region_addr_t prev_addr_reg_i,
	input  acw_pkg::addr_t        req_addr_i,
	input  logic                  req_write_i,
	output logic                  hit_o,
	output logic                  allow_o
);

	acw_pkg::region_mode_e mode;
	acw_pkg::region_addr_t word_addr;
	acw_pkg::region_addr_t napot_mask;
	logic tor_hit;
	logic napot_hit;

	assign mode = acw_pkg::region_mode_e'(cfg_i[acw_pkg::CFG_MODE_MSB:acw_pkg::CFG_MODE_LSB]);

	// compare in word units like the address registers
	assign word_addr = {2'b00, req_addr_i[31:2]};

	// top of range, lower bound comes from the previous region
	assign tor_hit = (word_addr >= prev_addr_reg_i) && (word_addr < addr_reg_i);

	// trailing ones plus the first zero select the size bits to ignore
	assign napot_mask = ~(addr_reg_i ^ (addr_reg_i + 32'd1));
	assign napot_hit = ((word_addr & napot_mask) == (addr_reg_i & napot_mask));

	always_comb begin
		case (mode)
			acw_pkg::mode_tor:   hit_o = tor_hit;
			acw_pkg::mode_napot: hit_o = napot_hit;
			default:             hit_o = 1'b0;
		endcase
	end

	assign allow_o = req_write_i ? cfg_i[acw_pkg::CFG_WRITE_BIT] : cfg_i[acw_pkg::CFG_READ_BIT];

endmodule

//--- src/acw_csr_bank.sv
// CPU register bank of the firewall, decodes the register port and holds region setup and denial state
`timescale 1ns/1ps

module acw_csr_bank #(
	parameter int          NUM_REGIONS = 8,
	parameter logic [21:0] BASE_ADDR   = 22'h0
) (
	input  logic                                    clk,
	input  logic                                    rst,
	input  logic                                    cpu_req_i,
	input  logic                                    cpu_write_i,
	input  acw_pkg::addr_t                          cpu_addr_i,
	input  acw_pkg::data_t                          cpu_wdata_i,
	output logic                                    cpu_rsp_valid_o,
	output acw_pkg::data_t                          cpu_rsp_rdata_o,
	output logic                                    cpu_rsp_err_o,
	output logic [NUM_REGIONS-1:0][7:0]             region_cfg_o,
	output acw_pkg::region_addr_t [NUM_REGIONS-1:0] region_addr_o,
	input  logic                                    deny_i,
	input  acw_pkg::addr_t                          denied_addr_i,
	input  logic                                    denied_write_i,
	input  acw_pkg::block_state_e                   state_i,
	output logic                                    go_idle_o,
	output logic                                    irq_o
);

	localparam int NUM_CFG_WORDS = NUM_REGIONS / 4;
	localparam int CFG_BASE      = acw_pkg::NUM_CTRL_REGS;
	localparam int ADDR_BASE     = CFG_BASE + NUM_CFG_WORDS;
	localparam int NUM_MAPPED    = ADDR_BASE + NUM_REGIONS;

	acw_pkg::reg_idx_t idx;
	logic base_hit;
	logic read_only;
	logic req_err;
	logic wr_en;
	logic [NUM_CFG_WORDS-1:0] cfg_sel;
	logic [NUM_REGIONS-1:0] addr_sel;
	acw_pkg::data_t rdata_d;

	logic [NUM_REGIONS-1:0][7:0] cfg_q;
	acw_pkg::region_addr_t [NUM_REGIONS-1:0] addr_q;
	acw_pkg::addr_t denied_addr_q;
	logic denied_write_q;
	logic intr_state_q;
	logic intr_enable_q;
	logic go_idle_q;
	logic rsp_valid_q;
	logic rsp_err_q;
	acw_pkg::data_t rsp_rdata_q;

	// address decode and access checks
	always_comb begin
		idx = cpu_addr_i[9:2];
		base_hit = (cpu_addr_i[31:10] == BASE_ADDR);
		read_only = (idx == acw_pkg::reg_denied_addr) || (idx == acw_pkg::reg_denied_type) ||
			(idx == acw_pkg::reg_state);
		req_err = !base_hit || (cpu_addr_i[1:0] != 2'b00) || (int'(idx) >= NUM_MAPPED) ||
			(cpu_write_i && read_only) || (!cpu_write_i && (idx == acw_pkg::reg_go_idle));
		wr_en = cpu_req_i && cpu_write_i && !req_err;
		for (int k = 0; k < NUM_CFG_WORDS; k++) begin
			cfg_sel[k] = (int'(idx) == CFG_BASE + k);
		end
		for (int i = 0; i < NUM_REGIONS; i++) begin
			addr_sel[i] = (int'(idx) == ADDR_BASE + i);
		end
	end

	// read data mux, writes and errors return zero
	always_comb begin
		case (idx)
			acw_pkg::reg_denied_addr: rdata_d = denied_addr_q;
			acw_pkg::reg_denied_type: rdata_d = {31'b0, denied_write_q};
			acw_pkg::reg_state:       rdata_d = {30'b0, state_i};
			acw_pkg::reg_intr_state:  rdata_d = {intr_state_q, 31'b0};
			acw_pkg::reg_intr_enable: rdata_d = {intr_enable_q, 31'b0};
			default:                  rdata_d = '0;
		endcase
		// region 4k+j lives in byte j of configuration word k
		for (int k = 0; k < NUM_CFG_WORDS; k++) begin
			if (cfg_sel[k]) begin
				for (int j = 0; j < 4; j++) begin
					rdata_d[8*j +: 8] = cfg_q[4*k+j];
				end
			end
		end
		for (int i = 0; i < NUM_REGIONS; i++) begin
			if (addr_sel[i]) begin
				rdata_d = addr_q[i];
			end
		end
		if (cpu_write_i || req_err) begin
			rdata_d = '0;
		end
	end

	always_ff @(posedge clk, negedge rst) begin
		if (!rst) begin
			cfg_q <= '0;
			addr_q <= '0;
			denied_addr_q <= '0;
			denied_write_q <= 1'b0;
			intr_state_q <= 1'b0;
			intr_enable_q <= 1'b0;
			go_idle_q <= 1'b0;
			rsp_valid_q <= 1'b0;
			rsp_err_q <= 1'b0;
		end else begin
			rsp_valid_q <= cpu_req_i;
			rsp_err_q <= cpu_req_i && req_err;
			go_idle_q <= wr_en && (idx == acw_pkg::reg_go_idle);
			if (wr_en) begin
				for (int k = 0; k < NUM_CFG_WORDS; k++) begin
					if (cfg_sel[k]) begin
						for (int j = 0; j < 4; j++) begin
							cfg_q[4*k+j] <= cpu_wdata_i[8*j +: 8];
						end
					end
				end
				for (int i = 0; i < NUM_REGIONS; i++) begin
					if (addr_sel[i]) begin
						addr_q[i] <= cpu_wdata_i;
					end
				end
				if (idx == acw_pkg::reg_intr_enable) begin
					intr_enable_q <= cpu_wdata_i[31];
				end
			end
			// a new denial wins over a clear in the same cycle
			if (deny_i) begin
				intr_state_q <= 1'b1;
			end else if (wr_en && (idx == acw_pkg::reg_intr_state)) begin
				intr_state_q <= 1'b0;
			end
			if (deny_i) begin
				denied_addr_q <= denied_addr_i;
				denied_write_q <= denied_write_i;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (cpu_req_i) begin
			rsp_rdata_q <= rdata_d;
		end
	end

	assign cpu_rsp_valid_o = rsp_valid_q;
	assign cpu_rsp_rdata_o = rsp_rdata_q;
	assign cpu_rsp_err_o = rsp_err_q;
	assign region_cfg_o = cfg_q;
	assign region_addr_o = addr_q;
	assign go_idle_o = go_idle_q;
	assign irq_o = intr_state_q & intr_enable_q;

endmodule

//--- src/acw_pkg.sv
// Shared widths, register map and encodings for the bus firewall, referenced by scoped names
package acw_pkg;

	// host or CPU byte address
	typedef logic [31:0] addr_t;

	// bus data word
	typedef logic [31:0] data_t;

	// region address register, byte address shifted right by two
	typedef logic [31:0] region_addr_t;

	// CPU word index from address bits 9:2
	typedef logic [7:0] reg_idx_t;

	// region matching modes, value 2 is unused and never matches
	typedef enum logic [1:0] {
		mode_off   = 2'd0,
		mode_tor   = 2'd1,
		mode_napot = 2'd3
	} region_mode_e;

	// host side blocking state
	typedef enum logic [1:0] {
		st_idle        = 2'd0,
		st_block_start = 2'd1,
		st_block_idle  = 2'd2,
		st_block_err   = 2'd3
	} block_state_e;

	// control register word indices
	localparam reg_idx_t reg_go_idle     = 8'd0;
	localparam reg_idx_t reg_denied_addr = 8'd1;
	localparam reg_idx_t reg_denied_type = 8'd2;
	localparam reg_idx_t reg_state       = 8'd3;
	localparam reg_idx_t reg_intr_state  = 8'd4;
	localparam reg_idx_t reg_intr_enable = 8'd5;

	// configuration words follow the control registers, then the region address words
	localparam int NUM_CTRL_REGS = 6;

	// fields of one region configuration byte
	localparam int CFG_READ_BIT  = 0;
	localparam int CFG_WRITE_BIT = 1;
	localparam int CFG_MODE_LSB  = 3;
	localparam int CFG_MODE_MSB  = 4;

endpackage
